//--- epu_decode.sv
/* First stage of the exception unit: takes one request over valid/ready,
   forms the MSR address, folds undefined opcodes into EINSN and registers it */
`timescale 1ns/1ps

module epu_decode (
   input  logic                clk,
   input  logic                rst,
   input  logic                in_valid,
   output logic                in_ready,
   input  epu_pkg::epu_req_t   in_req,
   input  logic                squash,
   output logic                dec_valid,
   input  logic                dec_ready,
   output epu_pkg::epu_dec_t   dec_op
);
   import epu_pkg::*;

   epu_dec_t dec_nxt;
   logic     accept;

   // Closed while a flush waits in the result stage
   assign in_ready = (~dec_valid | dec_ready) & ~squash;
   assign accept   = in_valid & in_ready;

   always_comb
   begin
      // MSR address is operand1 OR the low immediate bits
      dec_nxt.addr  = msr_addr_u'(in_req.operand1[MSR_ADDR_W-1:0] |
                                  in_req.imm[MSR_ADDR_W-1:0]);
      dec_nxt.wdata = in_req.operand2;
      dec_nxt.pc    = in_req.pc;
      dec_nxt.npc   = in_req.npc;
      case (in_req.opc)
         OPC_RMSR:    dec_nxt.opc = OPC_RMSR;
         OPC_WMSR:    dec_nxt.opc = OPC_WMSR;
         OPC_SYSCALL: dec_nxt.opc = OPC_SYSCALL;
         OPC_ERET:    dec_nxt.opc = OPC_ERET;
         default:     dec_nxt.opc = OPC_EINSN;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         dec_valid <= 1'b0;
      else if (accept)
         dec_valid <= 1'b1;
      else if (dec_ready | squash)
         dec_valid <= 1'b0;   // moved on, or younger than a flush
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         dec_op <= dec_nxt;
   end

   // Whatever code came in, the stage holds a defined opcode
   a_dec_opc_legal: assert property (@(posedge clk) disable iff (rst)
      accept |=> dec_op.opc inside {OPC_RMSR, OPC_WMSR, OPC_SYSCALL, OPC_ERET, OPC_EINSN});

endmodule

//--- epu_execute.sv
/* Second stage of the exception unit, combinational: reads MSR state, picks
   the exception action and builds the response; state changes on transfer */
`timescale 1ns/1ps

module epu_execute #(
   parameter int SR_NUM = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                dec_valid,
   output logic                dec_ready,
   input  epu_pkg::epu_dec_t   dec_op,
   output logic                res_valid,
   input  logic                res_ready,
   output epu_pkg::epu_resp_t  res_resp
);
   import epu_pkg::*;

   logic              xfer;
   logic              is_rmsr;
   logic              is_wmsr;
   logic              is_sys;
   logic              is_eret;
   logic              is_einsn;
   logic              psr_wr;
   logic              save;
   logic              restore;
   logic              wr_en;
   logic              elsa_set;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] epc;
   logic [DATA_W-1:0] epc_nxt;
   logic [DATA_W-1:0] elsa_nxt;

   // No storage here, so ready follows the result stage
   assign res_valid = dec_valid;
   assign dec_ready = res_ready;
   assign xfer      = dec_valid & res_ready;

   assign is_rmsr  = (dec_op.opc == OPC_RMSR);
   assign is_wmsr  = (dec_op.opc == OPC_WMSR);
   assign is_sys   = (dec_op.opc == OPC_SYSCALL);
   assign is_eret  = (dec_op.opc == OPC_ERET);
   assign is_einsn = (dec_op.opc == OPC_EINSN);

   // PSR write refetches from npc
   assign psr_wr = is_wmsr &
                   (dec_op.addr.ps_view.bank == BANK_PS) &
                   (dec_op.addr.ps_view.rsvd == '0) &
                   dec_op.addr.ps_view.sel[PS_PSR];

   ////////////////////////////////////////
   // Strobes into the register file
   assign save     = xfer & (is_sys | is_einsn);
   assign restore  = xfer & is_eret;
   assign wr_en    = xfer & is_wmsr;
   assign elsa_set = xfer & is_einsn;

   // Syscall resumes after itself, a faulting insn is retried
   assign epc_nxt  = is_sys ? {dec_op.npc, 2'b00} : {dec_op.pc, 2'b00};
   assign elsa_nxt = {dec_op.pc, 2'b00};

   always_comb
   begin
      res_resp.rdata = is_rmsr ? rd_data : '0;
      res_resp.flush = is_sys | is_einsn | is_eret | psr_wr;
      if (is_sys)
         res_resp.flush_tgt = SYSCALL_VECTOR[DATA_W-1 -: PC_W];
      else if (is_einsn)
         res_resp.flush_tgt = EINSN_VECTOR[DATA_W-1 -: PC_W];
      else if (is_eret)
         res_resp.flush_tgt = epc[DATA_W-1 -: PC_W];
      else if (psr_wr)
         res_resp.flush_tgt = dec_op.npc;
      else
         res_resp.flush_tgt = '0;
   end

   epu_msr_file #(
      .SR_NUM   (SR_NUM)
   ) u_msr_file (
      .clk      (clk),
      .rst      (rst),
      .rd_addr  (dec_op.addr),
      .rd_data  (rd_data),
      .wr_en    (wr_en),
      .wr_addr  (dec_op.addr),
      .wr_data  (dec_op.wdata),
      .save     (save),
      .restore  (restore),
      .epc_nxt  (epc_nxt),
      .elsa_set (elsa_set),
      .elsa_nxt (elsa_nxt),
      .epc      (epc)
   );

   // At most one source may touch PSR per edge
   a_one_psr_source: assert property (@(posedge clk) disable iff (rst)
      $onehot0({save, restore, wr_en & psr_wr}));

endmodule

//--- epu_msr_file.sv
/* Machine-specific registers of the exception unit: PSR, EPSR, EPC, ELSA and
   the scratch bank, with the save on exception entry and restore on ERET */
`timescale 1ns/1ps

module epu_msr_file #(
   parameter int SR_NUM = 8
) (
   input  logic                         clk,
   input  logic                         rst,
   input  epu_pkg::msr_addr_u           rd_addr,
   output logic [epu_pkg::DATA_W-1:0]   rd_data,
   input  logic                         wr_en,
   input  epu_pkg::msr_addr_u           wr_addr,
   input  logic [epu_pkg::DATA_W-1:0]   wr_data,
   input  logic                         save,
   input  logic                         restore,
   input  logic [epu_pkg::DATA_W-1:0]   epc_nxt,
   input  logic                         elsa_set,
   input  logic [epu_pkg::DATA_W-1:0]   elsa_nxt,
   output logic [epu_pkg::DATA_W-1:0]   epc
);
   import epu_pkg::*;

   // PSR and EPSR position in the data word
   localparam int PSR_LSB = 4;

   psr_t              psr;
   psr_t              epsr;
   psr_t              wr_psr;
   logic [DATA_W-1:0] elsa;
   logic [DATA_W-1:0] sr [SR_NUM];
   logic              rd_ps;
   logic              rd_sr;
   logic              wr_ps;
   logic              wr_sr;
   logic [DATA_W-1:0] psr_word;
   logic [DATA_W-1:0] epsr_word;
   logic [DATA_W-1:0] ps_data;
   logic [DATA_W-1:0] sr_data;

   // Nonzero reserved field means unmapped
   assign rd_ps = (rd_addr.ps_view.bank == BANK_PS) && (rd_addr.ps_view.rsvd == '0);
   assign rd_sr = (rd_addr.sr_view.bank == BANK_SR) && (rd_addr.sr_view.rsvd == '0);
   assign wr_ps = wr_en && (wr_addr.ps_view.bank == BANK_PS) && (wr_addr.ps_view.rsvd == '0);
   assign wr_sr = wr_en && (wr_addr.sr_view.bank == BANK_SR) && (wr_addr.sr_view.rsvd == '0);

   assign wr_psr = wr_data[PSR_LSB +: $bits(psr_t)];

   ////////////////////////////////////////
   // Read side
   always_comb
   begin
      psr_word = '0;
      psr_word[PSR_LSB +: $bits(psr_t)] = psr;
      epsr_word = '0;
      epsr_word[PSR_LSB +: $bits(psr_t)] = epsr;

      // Selects are one-hot, OR the picked registers together
      ps_data = ({DATA_W{rd_addr.ps_view.sel[PS_PSR]}}   & psr_word)    |
                ({DATA_W{rd_addr.ps_view.sel[PS_CPUID]}} & CPUID_VALUE) |
                ({DATA_W{rd_addr.ps_view.sel[PS_EPSR]}}  & epsr_word)   |
                ({DATA_W{rd_addr.ps_view.sel[PS_EPC]}}   & epc)         |
                ({DATA_W{rd_addr.ps_view.sel[PS_ELSA]}}  & elsa);

      // Index at or above SR_NUM matches nothing
      sr_data = '0;
      for (int i = 0; i < SR_NUM; i++)
      begin
         if (rd_addr.sr_view.idx == SR_IDX_W'(i))
            sr_data = sr[i];
      end

      rd_data = rd_ps ? ps_data : (rd_sr ? sr_data : '0);
   end

   ////////////////////////////////////////
   // Write side, exception entry and return first
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         psr  <= '{rm: 1'b1, default: 1'b0};
         epsr <= '0;
      end
      else if (save)
      begin
         epsr    <= psr;
         psr.rm  <= 1'b1;
         psr.ire <= 1'b0;
      end
      else if (restore)
         psr <= epsr;
      else if (wr_ps)
      begin
         if (wr_addr.ps_view.sel[PS_PSR])
            psr <= wr_psr;
         if (wr_addr.ps_view.sel[PS_EPSR])
            epsr <= wr_psr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         epc <= '0;
      else if (save)
         epc <= epc_nxt;
      else if (wr_ps && wr_addr.ps_view.sel[PS_EPC])
         epc <= wr_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         elsa <= '0;
      else if (elsa_set)
         elsa <= elsa_nxt;
      else if (wr_ps && wr_addr.ps_view.sel[PS_ELSA])
         elsa <= wr_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < SR_NUM; i++)
            sr[i] <= '0;
      end
      else if (wr_sr)
      begin
         for (int i = 0; i < SR_NUM; i++)
         begin
            if (wr_addr.sr_view.idx == SR_IDX_W'(i))
               sr[i] <= wr_data;
         end
      end
   end

endmodule

//--- epu_pkg.sv
/* Widths, opcodes, MSR address views and payload types of the exception unit
   Imported by every module of the unit and by its testbench */
package epu_pkg;

   localparam int DATA_W     = 32;
   localparam int PC_W       = 30;
   localparam int MSR_ADDR_W = 15;
   localparam int BANK_W     = 4;

   localparam logic [BANK_W-1:0] BANK_PS = 4'd0;
   localparam logic [BANK_W-1:0] BANK_SR = 4'd1;

   // One-hot selects inside the processor-state bank, bit 5 reserved
   localparam int PS_SEL_W = 6;
   localparam int PS_PSR   = 0;
   localparam int PS_CPUID = 1;
   localparam int PS_EPSR  = 2;
   localparam int PS_EPC   = 3;
   localparam int PS_ELSA  = 4;

   // Up to 16 scratch registers
   localparam int SR_IDX_W = 4;

   localparam logic [DATA_W-1:0] CPUID_VALUE    = 32'h4e43_0101;
   localparam logic [DATA_W-1:0] SYSCALL_VECTOR = 32'h0000_0100;
   localparam logic [DATA_W-1:0] EINSN_VECTOR   = 32'h0000_0200;

   typedef enum logic [2:0] {
      OPC_RMSR    = 3'd0,
      OPC_WMSR    = 3'd1,
      OPC_SYSCALL = 3'd2,
      OPC_ERET    = 3'd3,
      OPC_EINSN   = 3'd4
   } epu_opc_e;

   ////////////////////////////////////////
   // MSR address, read per bank
   typedef union packed {
      struct packed {
         logic [BANK_W-1:0]                     bank;
         logic [MSR_ADDR_W-BANK_W-PS_SEL_W-1:0] rsvd;
         logic [PS_SEL_W-1:0]                   sel;
      } ps_view;
      struct packed {
         logic [BANK_W-1:0]                     bank;
         logic [MSR_ADDR_W-BANK_W-SR_IDX_W-1:0] rsvd;
         logic [SR_IDX_W-1:0]                   idx;
      } sr_view;
   } msr_addr_u;

   // Sits at bits 9..4 of the MSR data word
   typedef struct packed {
      logic dce;
      logic ice;
      logic dmme;
      logic imme;
      logic ire;
      logic rm;
   } psr_t;

   ////////////////////////////////////////
   // Raw code from the issuer, may hold an undefined opcode
   typedef struct packed {
      logic [$bits(epu_opc_e)-1:0] opc;
      logic [PC_W-1:0]             pc;
      logic [PC_W-1:0]             npc;
      logic [DATA_W-1:0]           operand1;
      logic [DATA_W-1:0]           operand2;
      logic [DATA_W-1:0]           imm;
   } epu_req_t;

   typedef struct packed {
      epu_opc_e          opc;
      msr_addr_u         addr;
      logic [DATA_W-1:0] wdata;
      logic [PC_W-1:0]   pc;
      logic [PC_W-1:0]   npc;
   } epu_dec_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              flush;
      logic [PC_W-1:0]   flush_tgt;
   } epu_resp_t;

endpackage

//--- epu_result.sv
/* Output register of the exception unit: holds a response under back-pressure
   and raises squash while the held response flushes the pipeline */
`timescale 1ns/1ps

module epu_result (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 res_valid,
   output logic                 res_ready,
   input  epu_pkg::epu_resp_t   res_resp,
   output logic                 out_valid,
   input  logic                 out_ready,
   output epu_pkg::epu_resp_t   out_resp,
   output logic                 squash
);
   logic load;

   assign squash = out_valid & out_resp.flush;

   // Nothing may follow a flush in, the op behind it is dropped
   assign res_ready = ~out_valid | (out_ready & ~squash);
   assign load      = res_valid & res_ready;

   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= 1'b0;
      else if (load)
         out_valid <= 1'b1;
      else if (out_ready)
         out_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (load)
         out_resp <= res_resp;
   end

   // Stalled response stays put until writeback takes it
   a_resp_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_resp));

endmodule

//--- epu_top.sv
/* Exception processing unit top: decode, execute and result stages
   between the issuer handshake and the writeback handshake */
`timescale 1ns/1ps

module epu_top #(
   parameter int SR_NUM = 8
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  epu_pkg::epu_req_t    in_req,
   output logic                 out_valid,
   input  logic                 out_ready,
   output epu_pkg::epu_resp_t   out_resp
);
   import epu_pkg::*;

   logic      dec_valid;
   logic      dec_ready;
   epu_dec_t  dec_op;
   logic      res_valid;
   logic      res_ready;
   epu_resp_t res_resp;
   logic      squash;

   epu_decode u_decode (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .squash    (squash),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec_op    (dec_op)
   );

   epu_execute #(
      .SR_NUM    (SR_NUM)
   ) u_execute (
      .clk       (clk),
      .rst       (rst),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec_op    (dec_op),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_resp  (res_resp)
   );

   epu_result u_result (
      .clk       (clk),
      .rst       (rst),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_resp  (res_resp),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_resp  (out_resp),
      .squash    (squash)
   );

endmodule

//--- run.sh
#!/bin/sh
# Builds the exception unit testbench with Verilator and runs it
verilator --binary --timing --assert --top-module tb_epu -f sources.f -o sim_epu &&
./obj_dir/sim_epu | tee /dev/stderr | grep -qx "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- sources.f
epu_pkg.sv
epu_msr_file.sv
epu_decode.sv
epu_execute.sv
epu_result.sv
epu_top.sv
tb_epu.sv

//--- tb_epu.sv
/* Testbench for the exception unit with LCG stimulus, a register model that
   predicts each response, and assertions comparing every delivered response */
`timescale 1ns/1ps

module tb_epu;
   import epu_pkg::*;

   localparam int SR_NUM = 8;

   logic      clk;
   logic      rst;
   logic      in_valid;
   logic      in_ready;
   epu_req_t  in_req;
   logic      out_valid;
   logic      out_ready;
   epu_resp_t out_resp;

   // Register model
   logic [5:0]  m_psr;
   logic [5:0]  m_epsr;
   logic [31:0] m_epc;
   logic [31:0] m_elsa;
   logic [31:0] m_sr [16];
   logic        flush_pending;

   epu_resp_t exp_q[$];
   epu_resp_t exp_head;
   int        exp_cnt;
   int        errors;
   int        ops_sent;
   int        tests_run;
   int        tests_failed;
   string     test_name;
   logic [31:0] lcg_state;

   epu_top #(.SR_NUM(SR_NUM)) dut (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_resp  (out_resp)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lcg();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   ////////////////////////////////////////
   // Model of MSR reads and operation effects
   function automatic logic [31:0] read_msr(logic [14:0] a);
      logic [31:0] v;
      v = '0;
      if (a[14:11] == 4'd0 && a[10:6] == 5'd0)
      begin
         if (a[0]) v = v | {22'd0, m_psr, 4'd0};
         if (a[1]) v = v | CPUID_VALUE;
         if (a[2]) v = v | {22'd0, m_epsr, 4'd0};
         if (a[3]) v = v | m_epc;
         if (a[4]) v = v | m_elsa;
      end
      else if (a[14:11] == 4'd1 && a[10:4] == 7'd0 && int'(a[3:0]) < SR_NUM)
         v = m_sr[a[3:0]];
      return v;
   endfunction

   function automatic epu_resp_t predict(logic [2:0] opc, logic [29:0] pc,
                                         logic [29:0] npc, logic [14:0] a,
                                         logic [31:0] wd);
      epu_resp_t r;
      r = '0;
      if (opc == 3'd0)
         r.rdata = read_msr(a);
      else if (opc == 3'd1)
      begin
         if (a[14:11] == 4'd0 && a[10:6] == 5'd0)
         begin
            if (a[0])
            begin
               m_psr = wd[9:4];
               r.flush = 1'b1;
               r.flush_tgt = npc;
            end
            if (a[2]) m_epsr = wd[9:4];
            if (a[3]) m_epc = wd;
            if (a[4]) m_elsa = wd;
         end
         else if (a[14:11] == 4'd1 && a[10:4] == 7'd0 && int'(a[3:0]) < SR_NUM)
            m_sr[a[3:0]] = wd;
      end
      else if (opc == 3'd3)
      begin
         r.flush = 1'b1;
         r.flush_tgt = m_epc[31:2];
         m_psr = m_epsr;
      end
      else
      begin
         // SYSCALL and every other code enter an exception
         r.flush = 1'b1;
         m_epsr = m_psr;
         m_psr[0] = 1'b1;
         m_psr[1] = 1'b0;
         if (opc == 3'd2)
         begin
            r.flush_tgt = SYSCALL_VECTOR[31:2];
            m_epc = {npc, 2'b00};
         end
         else
         begin
            r.flush_tgt = EINSN_VECTOR[31:2];
            m_epc = {pc, 2'b00};
            m_elsa = {pc, 2'b00};
         end
      end
      return r;
   endfunction

   ////////////////////////////////////////
   // Stimulus
   task automatic send_op(logic [2:0] opc, logic [14:0] a, logic [31:0] wd);
      logic [31:0] r;
      logic [31:0] s;
      epu_resp_t   e;
      r = lcg();
      s = lcg();
      in_req.opc      = opc;
      in_req.pc       = r[29:0];
      in_req.npc      = r[29:0] + 30'd1;
      in_req.operand1 = {17'd0, a & s[14:0]};
      in_req.imm      = {s[31:15], a};
      in_req.operand2 = wd;
      in_valid = 1'b1;
      @(negedge clk);
      while (!in_ready)
         @(negedge clk);
      // Accepted on the coming edge unless a pending flush drops it
      if (!flush_pending)
      begin
         e = predict(opc, in_req.pc, in_req.npc, a, wd);
         if (e.flush)
            flush_pending = 1'b1;
         if (exp_cnt == 0)
            exp_head = e;
         exp_q.push_back(e);
         exp_cnt = exp_cnt + 1;
      end
      ops_sent = ops_sent + 1;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic drain();
      while (exp_cnt != 0)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic end_test(int err_start);
      drain();
      tests_run = tests_run + 1;
      if (errors != err_start)
         tests_failed = tests_failed + 1;
      $display("test %s finished with %0d errors", test_name, errors - err_start);
   endtask

   // Retire the queue head when a response leaves the DUT
   always @(posedge clk)
   begin
      if (!rst && out_valid && out_ready && exp_cnt != 0)
      begin
         if (exp_q[0].flush)
            flush_pending = 1'b0;
         void'(exp_q.pop_front());
         exp_cnt = exp_cnt - 1;
         if (exp_cnt != 0)
            exp_head = exp_q[0];
      end
   end

   always @(posedge clk)
   begin
      #1;
      out_ready = (lcg() % 4) != 0;
   end

   a_resp_expected: assert property (@(posedge clk) disable iff (rst)
      out_valid && out_ready |-> exp_cnt != 0)
      else
      begin
         $display("Test %s got a response that no operation should have produced",
                  test_name);
         errors = errors + 1;
      end

   a_resp_match: assert property (@(posedge clk) disable iff (rst)
      out_valid && out_ready && exp_cnt != 0 |-> out_resp == exp_head)
      else
      begin
         $display("Fail %s: expected %h actual %h", test_name, $sampled(exp_head),
                  $sampled(out_resp));
         errors = errors + 1;
      end

   ////////////////////////////////////////
   // Watchdog and test sequence
   initial
   begin
      int cycles;
      cycles = 0;
      while (cycles <= 200 * (ops_sent + 1) + 20)
      begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("Timeout: responses stopped arriving in test %s", test_name);
      $display("Something failed");
      $finish;
   end

   initial
   begin
      int          e0;
      logic [31:0] r;
      lcg_state = 32'h4485_c202;
      rst = 1'b1;
      in_valid = 1'b0;
      in_req = '0;
      out_ready = 1'b0;
      m_psr = 6'b000001;
      m_epsr = '0;
      m_epc = '0;
      m_elsa = '0;
      for (int i = 0; i < 16; i++)
         m_sr[i] = '0;
      flush_pending = 1'b0;
      exp_cnt = 0;
      exp_head = '0;
      errors = 0;
      ops_sent = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      test_name = "scratch";
      e0 = errors;
      for (int i = 0; i < 6; i++)
      begin
         r = lcg();
         send_op(3'd1, {4'd1, 7'd0, 1'b0, r[2:0]}, lcg());
         send_op(3'd0, {4'd1, 7'd0, 1'b0, r[2:0]}, '0);
      end
      send_op(3'd0, {4'd1, 7'd0, 1'b1, r[5:3]}, '0);
      send_op(3'd0, 15'h0002, '0);
      end_test(e0);

      test_name = "syscall";
      e0 = errors;
      send_op(3'd1, 15'h0001, lcg());
      drain();
      send_op(3'd2, '0, '0);
      drain();
      send_op(3'd0, 15'h0008, '0);
      send_op(3'd0, 15'h0004, '0);
      send_op(3'd0, 15'h0001, '0);
      end_test(e0);

      test_name = "illegal";
      e0 = errors;
      send_op(3'd5 + 3'(lcg() % 3), '0, '0);
      drain();
      send_op(3'd0, 15'h0008, '0);
      send_op(3'd0, 15'h0010, '0);
      end_test(e0);

      test_name = "eret";
      e0 = errors;
      send_op(3'd1, 15'h0008, lcg());
      send_op(3'd1, 15'h0004, lcg());
      send_op(3'd3, '0, '0);
      drain();
      send_op(3'd0, 15'h0001, '0);
      end_test(e0);

      test_name = "psr_write";
      e0 = errors;
      send_op(3'd1, 15'h0001, lcg());
      send_op(3'd1, {4'd1, 11'd3}, lcg());
      drain();
      send_op(3'd0, {4'd1, 11'd3}, '0);
      end_test(e0);

      test_name = "backpressure";
      e0 = errors;
      for (int i = 0; i < 20; i++)
      begin
         r = lcg();
         send_op({2'b00, r[8]}, {4'd1, 7'd0, 1'b0, r[2:0]}, lcg());
      end
      end_test(e0);

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
               errors);
      if (errors == 0 && tests_failed == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
